// File: game_defs.svh
/*
 * memory game constants
 *   sequence depth and index width
 *   show, key and alarm timer lengths
 *   tone half-period thresholds per sound
 */

`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// sequence store
`define GAME_MEM_DEPTH 32
`define GAME_ADDR_W 5

// timers, counted down to zero so a phase lasts value+1 cycles
`define GAME_COUNT_SEQ 33
`define GAME_DEC_SEQ 1
`define GAME_COUNT_KEY 33
`define GAME_COUNT_FIN 8

// tone thresholds, speaker half period is threshold+2 cycles
`define GAME_TONE_ERR 1
`define GAME_TONE_RED 2
`define GAME_TONE_GREEN 3
`define GAME_TONE_YELLOW 4
`define GAME_TONE_BLUE 5
`define GAME_TONE_WIN 6

`endif

// File: src/game_pkg.sv
/*
 * memory game types
 *   color_t      key color, also the stored sequence entry
 *   sound_t      sound request code to the tone generator
 *   game_state_t controller FSM states
 */

package game_pkg;

    typedef enum logic [1:0] {
        red    = 2'd0,
        green  = 2'd1,
        yellow = 2'd2,
        blue   = 2'd3
    } color_t;

    // low four codes line up with color_t
    typedef enum logic [2:0] {
        snd_red    = 3'd0,
        snd_green  = 3'd1,
        snd_yellow = 3'd2,
        snd_blue   = 3'd3,
        snd_win    = 3'd4,
        snd_loss   = 3'd5
    } sound_t;

    typedef enum logic [4:0] {
        st_idle, st_init, st_new_write,                                      // idle, new round
        st_show_addr, st_show_wait, st_show_on, st_show_lit, st_show_dark,   // show
        st_key_addr, st_key_wait, st_key_poll,                               // key wait
        st_key_led, st_key_lit, st_key_dark,                                 // key echo
        st_err_led, st_err_lit, st_err_dark,                                 // error echo
        st_rep_addr, st_rep_wait, st_rep_on, st_rep_lit, st_rep_dark,        // loss replay
        st_loss_lit, st_loss_dark,                                           // loss alarm
        st_win_tone, st_win_leds                                             // win alarm
    } game_state_t;

endpackage

// File: src/sequence_ram.sv
/*
 * sequence_ram
 *   color store for the game sequence
 *   single port, synchronous write, registered read
 *   read returns the old word when written at the same address
 */

`timescale 1ns/1ps
`include "game_defs.svh"

module sequence_ram import game_pkg::*; (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    wr,
    input  logic [`GAME_ADDR_W-1:0] addr,
    input  color_t                  wdata,
    output color_t                  rdata
);

    color_t mem [`GAME_MEM_DEPTH];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= red;
        end else begin
            rdata <= mem[addr];                // old contents first
        end
    end

    always_ff @(posedge clock) begin
        if (wr) begin
            mem[addr] <= wdata;
        end
    end

endmodule

// File: src/tone_generator.sv
/*
 * tone_generator
 *   maps the sound code to a half-period threshold
 *   square wave on speaker while play is high
 *   speaker low and counter cleared while play is low
 */

`timescale 1ns/1ps
`include "game_defs.svh"

module tone_generator import game_pkg::*; (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   play,
    input  sound_t sound,
    output logic   speaker
);

    logic [2:0] threshold;
    logic       tone_valid;
    logic [2:0] tone_cnt;

    always_comb begin
        tone_valid = 1'b1;
        case (sound)
            snd_red:    threshold = 3'(`GAME_TONE_RED);
            snd_green:  threshold = 3'(`GAME_TONE_GREEN);
            snd_yellow: threshold = 3'(`GAME_TONE_YELLOW);
            snd_blue:   threshold = 3'(`GAME_TONE_BLUE);
            snd_win:    threshold = 3'(`GAME_TONE_WIN);
            snd_loss:   threshold = 3'(`GAME_TONE_ERR);
            default: begin
                threshold  = 3'd0;
                tone_valid = 1'b0;             // undefined code, stay silent
            end
        endcase
    end

    // counter runs 0..threshold+1, so one half period is threshold+2 cycles
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tone_cnt <= 3'd0;
            speaker  <= 1'b0;
        end else if (!play) begin
            tone_cnt <= 3'd0;
            speaker  <= 1'b0;
        end else if (!tone_valid) begin
            tone_cnt <= 3'd0;                  // hold, speaker keeps its level
        end else if (tone_cnt > threshold) begin
            tone_cnt <= 3'd0;
            speaker  <= ~speaker;
        end else begin
            tone_cnt <= tone_cnt + 3'd1;
        end
    end

endmodule

// File: src/game_controller.sv
/*
 * game_controller
 *   game FSM for rounds, show, key check, loss replay and alarms
 *   phase timer and per-round shrinking timebase
 *   free-running color counter that supplies each new color
 *   key LED, loss LED and sound request drive
 */

`timescale 1ns/1ps
`include "game_defs.svh"

module game_controller import game_pkg::*; (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [3:0]              keys,
    output logic [3:0]              key_leds,
    output logic                    loss_led,
    output logic                    wr,
    output logic [`GAME_ADDR_W-1:0] addr,
    output color_t                  wdata,
    input  color_t                  rdata,
    output logic                    play,
    output sound_t                  sound
);

    localparam logic [5:0] SEQ_TIME = 6'(`GAME_COUNT_SEQ);
    localparam logic [5:0] SEQ_DEC  = 6'(`GAME_DEC_SEQ);
    localparam logic [5:0] KEY_TIME = 6'(`GAME_COUNT_KEY);
    localparam logic [5:0] FIN_TIME = 6'(`GAME_COUNT_FIN);
    localparam logic [`GAME_ADDR_W-1:0] LAST_ADDR = `GAME_ADDR_W'(`GAME_MEM_DEPTH - 1);

    game_state_t            state;
    logic [`GAME_ADDR_W-1:0] scan_idx;   // position being shown or checked
    logic [`GAME_ADDR_W-1:0] last_idx;   // last index of this round or replay pointer after loss
    logic [5:0]             count;
    logic [5:0]             timebase;
    logic [1:0]             color_cnt;
    color_t                 led_sel;    // key that was pressed
    logic                   key_hit;
    color_t                 key_color;
    logic                   timer_done;

    assign timer_done = (count == 6'd0);

    function automatic logic [3:0] led_of(color_t c);
        led_of = 4'b0001 << c;
    endfunction

    function automatic sound_t sound_of(color_t c);
        sound_of = sound_t'({1'b0, c});
    endfunction

    // each lit phase is followed by its own dark phase
    function automatic game_state_t dark_after(game_state_t s);
        case (s)
            st_show_lit: dark_after = st_show_dark;
            st_key_lit:  dark_after = st_key_dark;
            st_err_lit:  dark_after = st_err_dark;
            default:     dark_after = st_rep_dark;
        endcase
    endfunction

    // lowest key wins
    always_comb begin
        key_hit   = 1'b1;
        key_color = red;
        if (keys[0]) begin
            key_color = red;
        end else if (keys[1]) begin
            key_color = green;
        end else if (keys[2]) begin
            key_color = yellow;
        end else if (keys[3]) begin
            key_color = blue;
        end else begin
            key_hit = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            color_cnt <= 2'd0;
        end else begin
            color_cnt <= color_cnt + 2'd1;     // pseudo-random source
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            scan_idx <= '0;
            last_idx <= '0;
            count    <= 6'd0;
            timebase <= 6'd0;
            led_sel  <= red;
            key_leds <= 4'd0;
            loss_led <= 1'b0;
            wr       <= 1'b0;
            addr     <= '0;
            wdata    <= red;
            play     <= 1'b0;
            sound    <= snd_red;
        end else if (start) begin
            key_leds <= 4'd0;                  // restart from any state
            loss_led <= 1'b0;
            play     <= 1'b0;
            wr       <= 1'b0;
            state    <= st_init;
        end else begin
            case (state)
                st_idle: state <= st_idle;
                st_init: begin
                    last_idx <= '0;
                    timebase <= SEQ_TIME;
                    state    <= st_new_write;
                end
                st_new_write: begin
                    scan_idx <= '0;
                    wr       <= 1'b1;
                    addr     <= last_idx;      // append one color
                    wdata    <= color_t'(color_cnt);
                    state    <= st_show_addr;
                end
                st_show_addr: begin
                    wr    <= 1'b0;
                    addr  <= scan_idx;
                    state <= st_show_wait;
                end
                st_show_wait: state <= st_show_on;   // ram read latency
                st_show_on, st_rep_on: begin
                    key_leds <= led_of(rdata);
                    play     <= 1'b1;
                    sound    <= sound_of(rdata);
                    count    <= timebase;
                    state    <= (state == st_show_on) ? st_show_lit : st_rep_lit;
                end
                st_show_lit, st_key_lit, st_err_lit, st_rep_lit: begin
                    if (timer_done) begin
                        key_leds <= 4'd0;
                        play     <= 1'b0;
                        count    <= timebase;
                        state    <= dark_after(state);
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                st_show_dark: begin
                    if (!timer_done) begin
                        count <= count - 6'd1;
                    end else if (scan_idx != last_idx) begin
                        scan_idx <= scan_idx + `GAME_ADDR_W'(1);
                        state    <= st_show_addr;
                    end else begin
                        scan_idx <= '0;        // player's turn
                        state    <= st_key_addr;
                    end
                end
                st_key_addr: begin
                    count <= KEY_TIME;
                    addr  <= scan_idx;
                    state <= st_key_wait;
                end
                st_key_wait: state <= st_key_poll;
                st_key_poll: begin
                    if (timer_done) begin
                        loss_led <= 1'b1;      // key timeout
                        last_idx <= '0;
                        state    <= st_rep_addr;
                    end else if (key_hit) begin
                        led_sel <= key_color;
                        play    <= 1'b1;
                        count   <= timebase;
                        if (key_color == rdata) begin
                            sound <= sound_of(key_color);
                            state <= st_key_led;
                        end else begin
                            sound    <= snd_loss;
                            loss_led <= 1'b1;  // wrong key
                            state    <= st_err_led;
                        end
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                st_key_led, st_err_led: begin
                    key_leds <= led_of(led_sel);
                    state    <= (state == st_key_led) ? st_key_lit : st_err_lit;
                end
                st_key_dark: begin
                    if (!timer_done) begin
                        count <= count - 6'd1;
                    end else if (scan_idx != last_idx) begin
                        scan_idx <= scan_idx + `GAME_ADDR_W'(1);
                        state    <= st_key_addr;
                    end else if (last_idx != LAST_ADDR) begin
                        last_idx <= last_idx + `GAME_ADDR_W'(1);   // next round runs faster
                        timebase <= timebase - SEQ_DEC;
                        state    <= st_new_write;
                    end else begin
                        play  <= 1'b1;
                        sound <= snd_win;
                        count <= FIN_TIME;
                        state <= st_win_tone;
                    end
                end
                st_err_dark: begin
                    if (timer_done) begin
                        last_idx <= '0;
                        state    <= st_rep_addr;
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                st_rep_addr: begin
                    addr  <= last_idx;
                    state <= st_rep_wait;
                end
                st_rep_wait: state <= st_rep_on;
                st_rep_dark: begin
                    if (!timer_done) begin
                        count <= count - 6'd1;
                    end else if (last_idx != scan_idx) begin
                        last_idx <= last_idx + `GAME_ADDR_W'(1);
                        state    <= st_rep_addr;
                    end else begin
                        key_leds <= led_of(rdata);   // failed color starts the alarm
                        play     <= 1'b1;
                        sound    <= snd_loss;
                        count    <= FIN_TIME;
                        state    <= st_loss_lit;
                    end
                end
                st_loss_lit: begin
                    if (timer_done) begin
                        key_leds <= 4'd0;
                        play     <= 1'b0;
                        count    <= FIN_TIME;
                        state    <= st_loss_dark;
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                st_loss_dark: begin
                    if (timer_done) begin
                        key_leds <= led_of(rdata);
                        play     <= 1'b1;
                        sound    <= snd_loss;
                        count    <= FIN_TIME;
                        state    <= st_loss_lit;
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                st_win_tone: begin
                    if (timer_done) begin
                        key_leds <= 4'hf;      // all on and silent
                        play     <= 1'b0;
                        count    <= FIN_TIME;
                        state    <= st_win_leds;
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                st_win_leds: begin
                    if (timer_done) begin
                        key_leds <= 4'd0;
                        play     <= 1'b1;
                        sound    <= snd_win;
                        count    <= FIN_TIME;
                        state    <= st_win_tone;
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: src/memory_game.sv
/*
 * memory_game top level
 *   game_controller  FSM, timers, LEDs
 *   sequence_ram     stored color sequence
 *   tone_generator   speaker square wave
 */

`timescale 1ns/1ps
`include "game_defs.svh"

module memory_game import game_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       start,
    input  logic [3:0] keys,
    output logic [3:0] key_leds,
    output logic       loss_led,
    output logic       speaker
);

    logic                    wr;
    logic [`GAME_ADDR_W-1:0] addr;
    color_t                  wdata;
    color_t                  rdata;
    logic                    play;
    sound_t                  sound;

    game_controller u_ctrl (
        .clock    (clock),
        .rst_n    (rst_n),
        .start    (start),
        .keys     (keys),
        .key_leds (key_leds),
        .loss_led (loss_led),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .play     (play),
        .sound    (sound)
    );

    sequence_ram u_ram (
        .clock (clock),
        .rst_n (rst_n),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata)
    );

    tone_generator u_tone (
        .clock   (clock),
        .rst_n   (rst_n),
        .play    (play),
        .sound   (sound),
        .speaker (speaker)
    );

endmodule

// File: tests/memory_game_tb.sv
/*
 * memory_game testbench
 *   player model that learns the sequence from the show phase
 *   runs a wrong key game, a key timeout game and a full win
 *   concurrent assertions for the LED and loss invariants
 *   immediate assertions for flash timing, tones and alarms
 */

`timescale 1ns/1ps
`include "game_defs.svh"

module memory_game_tb;

    localparam int SEED       = 6;
    localparam int WAIT_LIMIT = 400;            // cycles allowed per wait
    localparam int FIN_LEN    = `GAME_COUNT_FIN + 1;

    logic       clock;
    logic       rst_n;
    logic       start;
    logic [3:0] keys;
    logic [3:0] key_leds;
    logic       loss_led;
    logic       speaker;

    logic [1:0] seq [`GAME_MEM_DEPTH];         // sequence as the player saw it
    int         errors;
    int         timeouts;

    memory_game dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .start    (start),
        .keys     (keys),
        .key_leds (key_leds),
        .loss_led (loss_led),
        .speaker  (speaker)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    no_full_leds_on_loss: assert property (@(posedge clock) disable iff (!rst_n)
        !(key_leds == 4'hf && loss_led))
        else begin
            errors++;
            $display("error at time %0d ns: all LEDs lit with loss LED high", $time);
        end

    loss_holds: assert property (@(posedge clock) disable iff (!rst_n)
        loss_led && !start |=> loss_led)
        else begin
            errors++;
            $display("error at time %0d ns: loss LED dropped without start", $time);
        end

    led_shape: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(key_leds) || key_leds == 4'hf)
        else begin
            errors++;
            $display("error at time %0d ns: key LEDs %b neither one-hot nor all", $time, key_leds);
        end

    function automatic logic [1:0] color_of(input logic [3:0] leds);
        int b;
        color_of = 2'd0;
        for (b = 0; b < 4; b++) begin
            if (leds[b]) color_of = 2'(b);
        end
    endfunction

    // speaker half period in cycles for a show color
    function automatic int tone_half(input logic [1:0] c);
        case (c)
            2'd0:    tone_half = `GAME_TONE_RED + 2;
            2'd1:    tone_half = `GAME_TONE_GREEN + 2;
            2'd2:    tone_half = `GAME_TONE_YELLOW + 2;
            default: tone_half = `GAME_TONE_BLUE + 2;
        endcase
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error at time %0d ns: %s", $time, msg);
    endtask

    task automatic timeout_exit(input string what);
        timeouts++;
        $display("timed out at %0d ns while waiting for %s", $time, what);
        $display("%0d value errors, %0d timeouts", errors, timeouts);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic wait_lit(input string what);
        int n;
        n = 0;
        while (key_leds == 4'd0 && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (key_leds == 4'd0) timeout_exit(what);
    endtask

    task automatic wait_dark(input string what);
        int n;
        n = 0;
        while (key_leds != 4'd0 && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (key_leds != 4'd0) timeout_exit(what);
    endtask

    // cycles the current LED pattern stays unchanged, bounded
    task automatic measure_lit(output logic [3:0] val, output int len);
        val = key_leds;
        len = 0;
        while (key_leds == val && len <= WAIT_LIMIT) begin
            len++;
            @(negedge clock);
        end
    endtask

    task automatic measure_dark(output int len);
        len = 0;
        while (key_leds == 4'd0 && len <= WAIT_LIMIT) begin
            len++;
            @(negedge clock);
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    // records round n and checks flash count, length, tone and dark gap
    task automatic watch_show(input int n);
        int         tb;
        int         i;
        int         k;
        logic [3:0] lit;
        logic [1:0] c;
        tb = `GAME_COUNT_SEQ - n * `GAME_DEC_SEQ;
        for (i = 0; i <= n; i++) begin
            wait_lit("a show flash");
            lit = key_leds;
            c   = color_of(lit);
            assert ($onehot(lit))
                else report_error($sformatf("round %0d flash %0d leds %b", n, i, lit));
            if (i < n) begin
                assert (c == seq[i])
                    else report_error($sformatf("round %0d flash %0d color %0d, expected %0d",
                                                n, i, c, seq[i]));
            end
            seq[i] = c;
            k = 0;
            while (key_leds == lit && k <= tb + 1) begin
                assert (speaker == (((k / tone_half(c)) % 2) == 1))
                    else report_error($sformatf("speaker %b in cycle %0d of color %0d",
                                                speaker, k, c));
                k++;
                @(negedge clock);
            end
            assert (k == tb + 1)
                else report_error($sformatf("round %0d flash lasted %0d, expected %0d",
                                            n, k, tb + 1));
            for (k = 0; k <= tb; k++) begin
                assert (key_leds == 4'd0) else report_error("LED lit in show dark gap");
                if (k > 0) begin                // tone stops one cycle after play
                    assert (!speaker) else report_error("speaker active in show dark gap");
                end
                if (k < tb) @(negedge clock);
            end
        end
    endtask

    task automatic press_key(input logic [1:0] c);
        keys = 4'b0001 << c;
        wait_lit("the key echo");
        assert (key_leds == 4'b0001 << c)
            else report_error($sformatf("echo leds %b for key %0d", key_leds, c));
        assert (!loss_led) else report_error("loss LED after a correct key");
        keys = 4'd0;
        wait_dark("the end of the key echo");
    endtask

    task automatic play_round(input int n);
        int i;
        watch_show(n);
        for (i = 0; i <= n; i++) begin
            press_key(seq[i]);
        end
    endtask

    // skips the replay, then checks two alarm blinks of one LED
    task automatic check_loss_alarm();
        logic [3:0] lit;
        logic [3:0] lit2;
        int         len;
        int         dark;
        int         flashes;
        len     = 0;
        flashes = 0;
        while (len != FIN_LEN && flashes < 40) begin
            wait_lit("a replay or loss alarm flash");
            measure_lit(lit, len);
            flashes++;
        end
        if (len != FIN_LEN) timeout_exit("the loss alarm blink");
        measure_dark(dark);
        assert (dark == FIN_LEN)
            else report_error($sformatf("loss alarm dark %0d, expected %0d", dark, FIN_LEN));
        measure_lit(lit2, len);
        assert (len == FIN_LEN && lit2 == lit && $onehot(lit2))
            else report_error($sformatf("loss alarm blink %b for %0d cycles", lit2, len));
        assert (loss_led) else report_error("loss LED low during loss alarm");
    endtask

    task automatic check_win();
        logic [3:0] lit;
        int         len;
        int         dark;
        int         i;
        wait_lit("the win blink");
        for (i = 0; i < 2; i++) begin
            measure_lit(lit, len);
            assert (lit == 4'hf && len == FIN_LEN)
                else report_error($sformatf("win blink %b for %0d cycles", lit, len));
            assert (!loss_led) else report_error("loss LED high after a win");
            measure_dark(dark);
            assert (dark == FIN_LEN)
                else report_error($sformatf("win dark %0d, expected %0d", dark, FIN_LEN));
        end
    endtask

    initial begin
        int         fail_round;
        int         fail_pos;
        int         r;
        int         i;
        int         n;
        logic [1:0] wrong;
        errors   = 0;
        timeouts = 0;
        rst_n    = 1'b0;
        start    = 1'b0;
        keys     = 4'd0;
        void'($urandom(SEED));
        repeat (2) @(negedge clock);
        rst_n = 1'b1;

        for (i = 0; i < 4; i++) begin                  // idle before start
            assert (key_leds == 4'd0 && !loss_led && !speaker)
                else report_error("outputs not idle after reset");
            @(negedge clock);
        end

        // wrong key in a random round
        fail_round = 1 + int'($urandom % 4);
        fail_pos   = int'($urandom % (fail_round + 1));
        pulse_start();
        for (r = 0; r < fail_round; r++) begin
            play_round(r);
        end
        watch_show(fail_round);
        for (i = 0; i < fail_pos; i++) begin
            press_key(seq[i]);
        end
        wrong = seq[fail_pos] + 2'(1 + $urandom % 3);
        keys  = 4'b0001 << wrong;
        n = 0;
        while (!loss_led && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!loss_led) timeout_exit("the loss LED after a wrong key");
        wait_lit("the wrong key echo");
        assert (key_leds == 4'b0001 << wrong)
            else report_error($sformatf("wrong key echo %b for key %0d", key_leds, wrong));
        keys = 4'd0;
        check_loss_alarm();

        // no key at all
        pulse_start();
        watch_show(0);
        n = 0;
        while (!loss_led && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!loss_led) timeout_exit("the loss LED after a key timeout");
        assert (n >= `GAME_COUNT_KEY + 1)
            else report_error($sformatf("key timeout after only %0d cycles", n));
        check_loss_alarm();

        // full game to the win display
        pulse_start();
        for (r = 0; r < `GAME_MEM_DEPTH; r++) begin
            play_round(r);
        end
        check_win();

        $display("%0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: memory_game.f
+incdir+.
src/game_pkg.sv
src/sequence_ram.sv
src/tone_generator.sv
src/game_controller.sv
src/memory_game.sv
tests/memory_game_tb.sv

// File: Makefile
# Verilator build, run and clean for the memory game testbench

VERILATOR ?= verilator
TOP       ?= memory_game_tb
FILELIST  ?= memory_game.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := game_defs.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, the header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
